/* verilog/rv_pkg.sv */
// widths, major opcodes and decode enums shared by the core
package rv_pkg;

  localparam int xlen_default = 64;
  localparam int inst_width = 32;
  localparam int reg_addr_width = 5;

  // major opcodes of the kept instructions
  localparam logic [6:0] opcode_op = 7'b0110011;
  localparam logic [6:0] opcode_op_imm = 7'b0010011;
  localparam logic [6:0] opcode_load = 7'b0000011;
  localparam logic [6:0] opcode_store = 7'b0100011;

  // instruction class carried down the pipe
  typedef enum logic [2:0] {
    op_alu_reg,
    op_alu_imm,
    op_load,
    op_store,
    op_nop
  } op_kind_t;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor
  } alu_op_t;

endpackage

/* verilog/fetch_stage.sv */
// program counter, fetch-port request and fetch-to-decode latch
`timescale 1ns/1ps

module fetch_stage #(
  parameter int xlen = rv_pkg::xlen_default,
  parameter logic [xlen-1:0] reset_pc = '0
) (
  input  logic clock,
  input  logic reset,
  input  logic id_allowin,
  output logic if_rw_valid,
  input  logic if_rw_ready,
  output logic [xlen-1:0] if_rw_addr,
  input  logic [xlen-1:0] if_r_data,
  output logic if_to_id_valid,
  output logic [xlen-1:0] if_to_id_pc,
  output logic [rv_pkg::inst_width-1:0] if_to_id_inst
);

  logic [xlen-1:0] pc;
  logic fetch_en;
  logic fetch_xfer;

  // a word may land when the latch is empty or decode drains it this cycle
  assign if_rw_valid = fetch_en && (!if_to_id_valid || id_allowin);
  assign if_rw_addr = pc;
  assign fetch_xfer = if_rw_valid && if_rw_ready;

  always_ff @(posedge clock) begin
    if (reset) begin
      fetch_en <= 1'b0;
      pc <= reset_pc;
      if_to_id_valid <= 1'b0;
    end else begin
      fetch_en <= 1'b1;
      if (fetch_xfer) begin
        pc <= pc + xlen'(4);
        if_to_id_valid <= 1'b1;
      end else if (id_allowin) begin
        if_to_id_valid <= 1'b0;
      end
    end
  end

  // instruction sits in the low word of the fetch data
  always_ff @(posedge clock) begin
    if (fetch_xfer) begin
      if_to_id_pc <= pc;
      if_to_id_inst <= if_r_data[rv_pkg::inst_width-1:0];
    end
  end

  // a waiting request keeps its address until the memory answers
  a_fetch_addr_stable: assert property (@(posedge clock) disable iff (reset)
    if_rw_valid && !if_rw_ready |=> if_rw_valid && $stable(if_rw_addr));

endmodule

/* verilog/register_file.sv */
// 32-entry general-purpose registers, two combinational reads and one write
`timescale 1ns/1ps

module register_file #(
  parameter int xlen = rv_pkg::xlen_default
) (
  input  logic clock,
  input  logic reset,
  input  logic [rv_pkg::reg_addr_width-1:0] rs1_addr,
  input  logic [rv_pkg::reg_addr_width-1:0] rs2_addr,
  output logic [xlen-1:0] rs1_data,
  output logic [xlen-1:0] rs2_data,
  input  logic wr_ena,
  input  logic [rv_pkg::reg_addr_width-1:0] wr_addr,
  input  logic [xlen-1:0] wr_data
);

  logic [xlen-1:0] regs [32];

  // x0 is cleared on reset and never written afterwards
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_ena && wr_addr != '0) begin
      regs[wr_addr] <= wr_data;
    end
  end

  assign rs1_data = regs[rs1_addr];
  assign rs2_data = regs[rs2_addr];

  a_x0_reads_zero: assert property (@(posedge clock) disable iff (reset)
    rs1_addr == '0 |-> rs1_data == '0);

endmodule

/* verilog/decode_stage.sv */
// decode latch, field extraction, operand read and read-after-write stall
`timescale 1ns/1ps

module decode_stage #(
  parameter int xlen = rv_pkg::xlen_default
) (
  input  logic clock,
  input  logic reset,
  input  logic if_to_id_valid,
  input  logic [xlen-1:0] if_to_id_pc,
  input  logic [rv_pkg::inst_width-1:0] if_to_id_inst,
  output logic id_allowin,
  input  logic ex_allowin,
  output logic [rv_pkg::reg_addr_width-1:0] rs1_addr,
  output logic [rv_pkg::reg_addr_width-1:0] rs2_addr,
  input  logic [xlen-1:0] rs1_data,
  input  logic [xlen-1:0] rs2_data,
  input  logic ex_dest_valid,
  input  logic [rv_pkg::reg_addr_width-1:0] ex_dest,
  input  logic mem_dest_valid,
  input  logic [rv_pkg::reg_addr_width-1:0] mem_dest,
  input  logic wb_dest_valid,
  input  logic [rv_pkg::reg_addr_width-1:0] wb_dest,
  output logic id_to_ex_valid,
  output logic [xlen-1:0] id_to_ex_pc,
  output logic [rv_pkg::inst_width-1:0] id_to_ex_inst,
  output rv_pkg::op_kind_t id_to_ex_kind,
  output rv_pkg::alu_op_t id_to_ex_alu_op,
  output logic [xlen-1:0] id_to_ex_src1,
  output logic [xlen-1:0] id_to_ex_src2,
  output logic [xlen-1:0] id_to_ex_imm,
  output logic [rv_pkg::reg_addr_width-1:0] id_to_ex_rd
);

  logic id_valid;
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic alu_f3;
  logic use_rs1;
  logic use_rs2;
  logic has_rd;
  logic rs1_hit;
  logic rs2_hit;
  logic stall;

  assign opcode = id_to_ex_inst[6:0];
  assign funct3 = id_to_ex_inst[14:12];
  assign funct7 = id_to_ex_inst[31:25];
  assign rs1_addr = id_to_ex_inst[19:15];
  assign rs2_addr = id_to_ex_inst[24:20];
  assign alu_f3 = funct3 inside {3'b000, 3'b100, 3'b110, 3'b111};

  // anything outside the kept set falls through as op_nop
  always_comb begin
    id_to_ex_kind = rv_pkg::op_nop;
    case (opcode)
      rv_pkg::opcode_op:
        if (alu_f3 && (funct7 == 7'h00 || (funct7 == 7'h20 && funct3 == 3'b000)))
          id_to_ex_kind = rv_pkg::op_alu_reg;
      rv_pkg::opcode_op_imm:
        if (alu_f3)
          id_to_ex_kind = rv_pkg::op_alu_imm;
      rv_pkg::opcode_load:
        if (funct3 == 3'b011)
          id_to_ex_kind = rv_pkg::op_load;
      rv_pkg::opcode_store:
        if (funct3 == 3'b011)
          id_to_ex_kind = rv_pkg::op_store;
      default: ;
    endcase
  end

  // loads and stores land on add for address generation
  always_comb begin
    case (funct3)
      3'b100: id_to_ex_alu_op = rv_pkg::alu_xor;
      3'b110: id_to_ex_alu_op = rv_pkg::alu_or;
      3'b111: id_to_ex_alu_op = rv_pkg::alu_and;
      default: id_to_ex_alu_op = rv_pkg::alu_add;
    endcase
    if (id_to_ex_kind == rv_pkg::op_alu_reg && funct7[5])
      id_to_ex_alu_op = rv_pkg::alu_sub;
  end

  assign id_to_ex_imm = (id_to_ex_kind == rv_pkg::op_store) ?
      {{(xlen-12){id_to_ex_inst[31]}}, funct7, id_to_ex_inst[11:7]} :
      {{(xlen-12){id_to_ex_inst[31]}}, id_to_ex_inst[31:20]};

  assign use_rs1 = id_to_ex_kind != rv_pkg::op_nop;
  assign use_rs2 = id_to_ex_kind inside {rv_pkg::op_alu_reg, rv_pkg::op_store};
  assign has_rd = id_to_ex_kind inside {rv_pkg::op_alu_reg, rv_pkg::op_alu_imm, rv_pkg::op_load};
  // rd forced to x0 for classes without a destination
  assign id_to_ex_rd = has_rd ? id_to_ex_inst[11:7] : '0;
  assign id_to_ex_src1 = rs1_data;
  assign id_to_ex_src2 = rs2_data;

  // downstream flags are only raised for nonzero destinations
  assign rs1_hit = (ex_dest_valid && ex_dest == rs1_addr) ||
      (mem_dest_valid && mem_dest == rs1_addr) || (wb_dest_valid && wb_dest == rs1_addr);
  assign rs2_hit = (ex_dest_valid && ex_dest == rs2_addr) ||
      (mem_dest_valid && mem_dest == rs2_addr) || (wb_dest_valid && wb_dest == rs2_addr);
  assign stall = id_valid && ((use_rs1 && rs1_hit) || (use_rs2 && rs2_hit));

  assign id_to_ex_valid = id_valid && !stall;
  assign id_allowin = !id_valid || (!stall && ex_allowin);

  always_ff @(posedge clock) begin
    if (reset) begin
      id_valid <= 1'b0;
    end else if (id_allowin) begin
      id_valid <= if_to_id_valid;
    end
  end

  always_ff @(posedge clock) begin
    if (if_to_id_valid && id_allowin) begin
      id_to_ex_pc <= if_to_id_pc;
      id_to_ex_inst <= if_to_id_inst;
    end
  end

endmodule

/* verilog/execute_stage.sv */
// execute latch, ALU and load/store address generation
`timescale 1ns/1ps

module execute_stage #(
  parameter int xlen = rv_pkg::xlen_default
) (
  input  logic clock,
  input  logic reset,
  input  logic id_to_ex_valid,
  input  logic [xlen-1:0] id_to_ex_pc,
  input  logic [rv_pkg::inst_width-1:0] id_to_ex_inst,
  input  rv_pkg::op_kind_t id_to_ex_kind,
  input  rv_pkg::alu_op_t id_to_ex_alu_op,
  input  logic [xlen-1:0] id_to_ex_src1,
  input  logic [xlen-1:0] id_to_ex_src2,
  input  logic [xlen-1:0] id_to_ex_imm,
  input  logic [rv_pkg::reg_addr_width-1:0] id_to_ex_rd,
  output logic ex_allowin,
  input  logic mem_allowin,
  output logic ex_dest_valid,
  output logic [rv_pkg::reg_addr_width-1:0] ex_dest,
  output logic ex_to_mem_valid,
  output logic [xlen-1:0] ex_to_mem_pc,
  output logic [rv_pkg::inst_width-1:0] ex_to_mem_inst,
  output rv_pkg::op_kind_t ex_to_mem_kind,
  output logic [xlen-1:0] ex_to_mem_result,
  output logic [xlen-1:0] ex_to_mem_store_data,
  output logic [rv_pkg::reg_addr_width-1:0] ex_to_mem_rd
);

  rv_pkg::alu_op_t ex_alu_op;
  logic [xlen-1:0] ex_src1;
  logic [xlen-1:0] ex_imm;
  logic [xlen-1:0] operand_b;

  // single-cycle stage, done as soon as it holds an item
  assign ex_allowin = !ex_to_mem_valid || mem_allowin;
  assign ex_dest_valid = ex_to_mem_valid && ex_to_mem_rd != '0;
  assign ex_dest = ex_to_mem_rd;

  always_ff @(posedge clock) begin
    if (reset) begin
      ex_to_mem_valid <= 1'b0;
    end else if (ex_allowin) begin
      ex_to_mem_valid <= id_to_ex_valid;
    end
  end

  always_ff @(posedge clock) begin
    if (id_to_ex_valid && ex_allowin) begin
      ex_to_mem_pc <= id_to_ex_pc;
      ex_to_mem_inst <= id_to_ex_inst;
      ex_to_mem_kind <= id_to_ex_kind;
      ex_alu_op <= id_to_ex_alu_op;
      ex_src1 <= id_to_ex_src1;
      ex_to_mem_store_data <= id_to_ex_src2;
      ex_imm <= id_to_ex_imm;
      ex_to_mem_rd <= id_to_ex_rd;
    end
  end

  // rs2 value doubles as the second ALU operand for register ops
  assign operand_b = (ex_to_mem_kind == rv_pkg::op_alu_reg) ? ex_to_mem_store_data : ex_imm;

  always_comb begin
    case (ex_alu_op)
      rv_pkg::alu_add: ex_to_mem_result = ex_src1 + operand_b;
      rv_pkg::alu_sub: ex_to_mem_result = ex_src1 - operand_b;
      rv_pkg::alu_and: ex_to_mem_result = ex_src1 & operand_b;
      rv_pkg::alu_or: ex_to_mem_result = ex_src1 | operand_b;
      rv_pkg::alu_xor: ex_to_mem_result = ex_src1 ^ operand_b;
      default: ex_to_mem_result = '0;
    endcase
  end

endmodule

/* verilog/memory_stage.sv */
// memory latch and data-port load/store sequencing
`timescale 1ns/1ps

module memory_stage #(
  parameter int xlen = rv_pkg::xlen_default
) (
  input  logic clock,
  input  logic reset,
  input  logic ex_to_mem_valid,
  input  logic [xlen-1:0] ex_to_mem_pc,
  input  logic [rv_pkg::inst_width-1:0] ex_to_mem_inst,
  input  rv_pkg::op_kind_t ex_to_mem_kind,
  input  logic [xlen-1:0] ex_to_mem_result,
  input  logic [xlen-1:0] ex_to_mem_store_data,
  input  logic [rv_pkg::reg_addr_width-1:0] ex_to_mem_rd,
  output logic mem_allowin,
  input  logic wb_allowin,
  output logic mem_dest_valid,
  output logic [rv_pkg::reg_addr_width-1:0] mem_dest,
  output logic mem_rw_valid,
  input  logic mem_rw_ready,
  output logic mem_rw_req,
  output logic [xlen-1:0] mem_rw_addr,
  output logic [xlen-1:0] mem_w_data,
  input  logic [xlen-1:0] mem_r_data,
  output logic mem_to_wb_valid,
  output logic [xlen-1:0] mem_to_wb_pc,
  output logic [rv_pkg::inst_width-1:0] mem_to_wb_inst,
  output logic mem_to_wb_wen,
  output logic [rv_pkg::reg_addr_width-1:0] mem_to_wb_rd,
  output logic [xlen-1:0] mem_to_wb_data
);

  logic mem_valid;
  rv_pkg::op_kind_t mem_kind;
  logic [xlen-1:0] mem_result;
  logic [xlen-1:0] load_data;
  logic access;
  logic xfer;
  logic req_done;
  logic ready_go;

  assign access = mem_kind == rv_pkg::op_load || mem_kind == rv_pkg::op_store;
  // one request per item, dropped once its transfer has happened
  assign mem_rw_valid = mem_valid && access && !req_done;
  assign mem_rw_req = mem_kind == rv_pkg::op_store;
  assign mem_rw_addr = mem_result;
  assign xfer = mem_rw_valid && mem_rw_ready;

  assign ready_go = !access || xfer || req_done;
  assign mem_to_wb_valid = mem_valid && ready_go;
  assign mem_allowin = !mem_valid || (ready_go && wb_allowin);

  // decode zeroes rd for stores and no-ops
  assign mem_to_wb_wen = mem_to_wb_rd != '0;
  assign mem_dest_valid = mem_valid && mem_to_wb_wen;
  assign mem_dest = mem_to_wb_rd;
  assign mem_to_wb_data = (mem_kind != rv_pkg::op_load) ? mem_result :
      (req_done ? load_data : mem_r_data);

  always_ff @(posedge clock) begin
    if (reset) begin
      mem_valid <= 1'b0;
      req_done <= 1'b0;
    end else begin
      if (mem_allowin) begin
        mem_valid <= ex_to_mem_valid;
      end
      if (mem_to_wb_valid && wb_allowin) begin
        req_done <= 1'b0;
      end else if (xfer) begin
        req_done <= 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (ex_to_mem_valid && mem_allowin) begin
      mem_to_wb_pc <= ex_to_mem_pc;
      mem_to_wb_inst <= ex_to_mem_inst;
      mem_kind <= ex_to_mem_kind;
      mem_result <= ex_to_mem_result;
      mem_w_data <= ex_to_mem_store_data;
      mem_to_wb_rd <= ex_to_mem_rd;
    end
    // keeps load data if writeback cannot take it yet
    if (xfer) begin
      load_data <= mem_r_data;
    end
  end

  a_mem_valid_held: assert property (@(posedge clock) disable iff (reset)
    mem_rw_valid && !mem_rw_ready |=> mem_rw_valid);

endmodule

/* verilog/writeback_stage.sv */
// writeback latch, register write and retire ports
`timescale 1ns/1ps

module writeback_stage #(
  parameter int xlen = rv_pkg::xlen_default
) (
  input  logic clock,
  input  logic reset,
  input  logic mem_to_wb_valid,
  input  logic [xlen-1:0] mem_to_wb_pc,
  input  logic [rv_pkg::inst_width-1:0] mem_to_wb_inst,
  input  logic mem_to_wb_wen,
  input  logic [rv_pkg::reg_addr_width-1:0] mem_to_wb_rd,
  input  logic [xlen-1:0] mem_to_wb_data,
  output logic wb_allowin,
  output logic wb_dest_valid,
  output logic [rv_pkg::reg_addr_width-1:0] wb_dest,
  output logic wr_ena,
  output logic [rv_pkg::reg_addr_width-1:0] wr_addr,
  output logic [xlen-1:0] wr_data,
  output logic retire_valid,
  output logic [xlen-1:0] retire_pc,
  output logic [rv_pkg::inst_width-1:0] retire_inst,
  output logic retire_wen,
  output logic [rv_pkg::reg_addr_width-1:0] retire_rd,
  output logic [xlen-1:0] retire_data
);

  // every item spends exactly one cycle here
  assign wb_allowin = 1'b1;

  always_ff @(posedge clock) begin
    if (reset) begin
      retire_valid <= 1'b0;
    end else begin
      retire_valid <= mem_to_wb_valid;
    end
  end

  always_ff @(posedge clock) begin
    if (mem_to_wb_valid) begin
      retire_pc <= mem_to_wb_pc;
      retire_inst <= mem_to_wb_inst;
      retire_wen <= mem_to_wb_wen;
      retire_rd <= mem_to_wb_rd;
      retire_data <= mem_to_wb_data;
    end
  end

  // register write lands on the edge the item retires
  assign wr_ena = retire_valid && retire_wen;
  assign wr_addr = retire_rd;
  assign wr_data = retire_data;
  assign wb_dest_valid = wr_ena;
  assign wb_dest = retire_rd;

endmodule

/* verilog/cpu_core.sv */
// five-stage RV64 core top level wiring the stages and the register file
`timescale 1ns/1ps

module cpu_core #(
  parameter int xlen = rv_pkg::xlen_default,
  parameter logic [xlen-1:0] reset_pc = '0
) (
  input  logic clock,
  input  logic reset,
  output logic if_rw_valid,
  input  logic if_rw_ready,
  output logic [xlen-1:0] if_rw_addr,
  input  logic [xlen-1:0] if_r_data,
  output logic mem_rw_valid,
  input  logic mem_rw_ready,
  output logic mem_rw_req,
  output logic [xlen-1:0] mem_rw_addr,
  output logic [xlen-1:0] mem_w_data,
  input  logic [xlen-1:0] mem_r_data,
  output logic retire_valid,
  output logic [xlen-1:0] retire_pc,
  output logic [rv_pkg::inst_width-1:0] retire_inst,
  output logic retire_wen,
  output logic [rv_pkg::reg_addr_width-1:0] retire_rd,
  output logic [xlen-1:0] retire_data
);

  // stage handshakes
  logic if_to_id_valid;
  logic id_to_ex_valid;
  logic ex_to_mem_valid;
  logic mem_to_wb_valid;
  logic id_allowin;
  logic ex_allowin;
  logic mem_allowin;
  logic wb_allowin;

  logic [xlen-1:0] if_to_id_pc;
  logic [rv_pkg::inst_width-1:0] if_to_id_inst;

  logic [xlen-1:0] id_to_ex_pc;
  logic [rv_pkg::inst_width-1:0] id_to_ex_inst;
  rv_pkg::op_kind_t id_to_ex_kind;
  rv_pkg::alu_op_t id_to_ex_alu_op;
  logic [xlen-1:0] id_to_ex_src1;
  logic [xlen-1:0] id_to_ex_src2;
  logic [xlen-1:0] id_to_ex_imm;
  logic [rv_pkg::reg_addr_width-1:0] id_to_ex_rd;

  logic [xlen-1:0] ex_to_mem_pc;
  logic [rv_pkg::inst_width-1:0] ex_to_mem_inst;
  rv_pkg::op_kind_t ex_to_mem_kind;
  logic [xlen-1:0] ex_to_mem_result;
  logic [xlen-1:0] ex_to_mem_store_data;
  logic [rv_pkg::reg_addr_width-1:0] ex_to_mem_rd;

  logic [xlen-1:0] mem_to_wb_pc;
  logic [rv_pkg::inst_width-1:0] mem_to_wb_inst;
  logic mem_to_wb_wen;
  logic [rv_pkg::reg_addr_width-1:0] mem_to_wb_rd;
  logic [xlen-1:0] mem_to_wb_data;

  // hazard destinations back to decode
  logic ex_dest_valid;
  logic mem_dest_valid;
  logic wb_dest_valid;
  logic [rv_pkg::reg_addr_width-1:0] ex_dest;
  logic [rv_pkg::reg_addr_width-1:0] mem_dest;
  logic [rv_pkg::reg_addr_width-1:0] wb_dest;

  // register file ports
  logic [rv_pkg::reg_addr_width-1:0] rs1_addr;
  logic [rv_pkg::reg_addr_width-1:0] rs2_addr;
  logic [xlen-1:0] rs1_data;
  logic [xlen-1:0] rs2_data;
  logic wr_ena;
  logic [rv_pkg::reg_addr_width-1:0] wr_addr;
  logic [xlen-1:0] wr_data;

  // port names line up across stages
  fetch_stage #(.xlen(xlen), .reset_pc(reset_pc)) u_fetch_stage (.*);
  decode_stage #(.xlen(xlen)) u_decode_stage (.*);
  execute_stage #(.xlen(xlen)) u_execute_stage (.*);
  memory_stage #(.xlen(xlen)) u_memory_stage (.*);
  writeback_stage #(.xlen(xlen)) u_writeback_stage (.*);
  register_file #(.xlen(xlen)) u_register_file (.*);

endmodule

/* bench/tb_memory.sv */
// instruction and data memory model with random ready back-pressure on both ports
`timescale 1ns/1ps

module tb_memory (
  input  logic clock,
  input  logic reset,
  input  logic if_rw_valid,
  output logic if_rw_ready,
  input  logic [63:0] if_rw_addr,
  output logic [63:0] if_r_data,
  input  logic mem_rw_valid,
  output logic mem_rw_ready,
  input  logic mem_rw_req,
  input  logic [63:0] mem_rw_addr,
  input  logic [63:0] mem_w_data,
  output logic [63:0] mem_r_data,
  output logic store_seen,
  output logic [63:0] store_addr,
  output logic [63:0] store_data
);

  // one instruction per word, loaded by the testbench
  logic [31:0] imem [256];
  logic [63:0] dmem [64];

  // fill depends on the full byte address of each doubleword
  initial begin
    logic [63:0] byte_addr;
    if_rw_ready = 1'b0;
    mem_rw_ready = 1'b0;
    for (int i = 0; i < 64; i++) begin
      byte_addr = 64'(i) << 3;
      dmem[i] = (byte_addr * 64'h9e37_79b9_7f4a_7c15) ^ {byte_addr[31:0], ~byte_addr[31:0]};
    end
  end

  // read data is valid in the transfer cycle
  assign if_r_data = {32'h0, imem[if_rw_addr[9:2]]};
  assign mem_r_data = dmem[mem_rw_addr[8:3]];

  // ready redrawn every falling edge, whether or not a request waits
  always @(negedge clock) begin
    if_rw_ready = ($urandom % 4) != 0;
    mem_rw_ready = ($urandom % 2) != 0;
  end

  always @(posedge clock) begin
    if (!reset && mem_rw_valid && mem_rw_ready && mem_rw_req) begin
      dmem[mem_rw_addr[8:3]] = mem_w_data;
    end
  end

  // registered copy of each write transfer for the comparator
  always @(posedge clock) begin
    if (reset) begin
      store_seen <= 1'b0;
    end else begin
      store_seen <= mem_rw_valid && mem_rw_ready && mem_rw_req;
    end
    store_addr <= mem_rw_addr;
    store_data <= mem_w_data;
  end

endmodule

/* bench/cpu_core_tb.sv */
// testbench for cpu_core with program, reference model, comparator and timeout
`timescale 1ns/1ps

module cpu_core_tb;

  logic clock;
  logic reset;
  logic if_rw_valid;
  logic if_rw_ready;
  logic [63:0] if_rw_addr;
  logic [63:0] if_r_data;
  logic mem_rw_valid;
  logic mem_rw_ready;
  logic mem_rw_req;
  logic [63:0] mem_rw_addr;
  logic [63:0] mem_w_data;
  logic [63:0] mem_r_data;
  logic retire_valid;
  logic [63:0] retire_pc;
  logic [31:0] retire_inst;
  logic retire_wen;
  logic [4:0] retire_rd;
  logic [63:0] retire_data;
  logic store_seen;
  logic [63:0] store_addr;
  logic [63:0] store_data;

  logic [31:0] prog [$];
  logic [63:0] model_regs [32];
  logic [63:0] model_mem [64];
  // expected retire records and write transfers, oldest first
  logic [63:0] exp_pc [$];
  logic [31:0] exp_inst [$];
  logic exp_wen [$];
  logic [4:0] exp_rd [$];
  logic [63:0] exp_data [$];
  logic [63:0] exp_store_addr [$];
  logic [63:0] exp_store_data [$];
  int cycle_count = 0;
  int cycle_limit = 0;

  cpu_core #(.xlen(64), .reset_pc(64'h0)) u_cpu_core (.*);

  tb_memory u_tb_memory (.*);

  always #50 clock = ~clock;

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("** FAIL **");
    $fatal(1, "simulation stopped");
  endtask

  task automatic compare_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
    if (actual !== expected) begin
      stop_run($sformatf("MISMATCH %s: actual 0x%h expected 0x%h", name, actual, expected));
    end
  endtask

  function automatic logic [31:0] enc_r(input int f7, input int f3, input int rd,
                                        input int rs1, input int rs2);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
  endfunction

  function automatic logic [31:0] enc_i(input int op, input int f3, input int rd,
                                        input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
  endfunction

  function automatic logic [31:0] enc_s(input int rs2, input int rs1, input int imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b011, imm[4:0], 7'h23};
  endfunction

  function automatic logic [63:0] alu_result(input logic [2:0] f3, input logic sub,
                                             input logic [63:0] a, input logic [63:0] b);
    case (f3)
      3'd4: return a ^ b;
      3'd6: return a | b;
      3'd7: return a & b;
      default: return sub ? a - b : a + b;
    endcase
  endfunction

  // one instruction of the ISA model, queueing its retire record and store
  function automatic void step_model(input logic [31:0] inst, input logic [63:0] pc);
    logic [6:0] opcode;
    logic [4:0] rd;
    logic [2:0] f3;
    logic [6:0] f7;
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] imm_i;
    logic [63:0] imm_s;
    logic [63:0] addr;
    logic [63:0] result;
    logic wen;
    logic alu_f3;
    opcode = inst[6:0];
    rd = inst[11:7];
    f3 = inst[14:12];
    f7 = inst[31:25];
    a = model_regs[inst[19:15]];
    b = model_regs[inst[24:20]];
    imm_i = {{52{inst[31]}}, inst[31:20]};
    imm_s = {{52{inst[31]}}, inst[31:25], inst[11:7]};
    alu_f3 = (f3 == 3'd0) || (f3 == 3'd4) || (f3 == 3'd6) || (f3 == 3'd7);
    wen = 1'b0;
    result = '0;
    if (opcode == 7'h33 && alu_f3 && (f7 == 7'h00 || (f7 == 7'h20 && f3 == 3'd0))) begin
      wen = 1'b1;
      result = alu_result(f3, f7[5], a, b);
    end else if (opcode == 7'h13 && alu_f3) begin
      wen = 1'b1;
      result = alu_result(f3, 1'b0, a, imm_i);
    end else if (opcode == 7'h03 && f3 == 3'd3) begin
      addr = a + imm_i;
      wen = 1'b1;
      result = model_mem[addr[8:3]];
    end else if (opcode == 7'h23 && f3 == 3'd3) begin
      addr = a + imm_s;
      model_mem[addr[8:3]] = b;
      exp_store_addr.push_back(addr);
      exp_store_data.push_back(b);
    end
    // x0 never takes a write
    if (rd == 5'd0) begin
      wen = 1'b0;
    end
    if (wen) begin
      model_regs[rd] = result;
    end
    exp_pc.push_back(pc);
    exp_inst.push_back(inst);
    exp_wen.push_back(wen);
    exp_rd.push_back(rd);
    exp_data.push_back(result);
  endfunction

  task automatic build_program();
    // dependent ALU chain, immediates of both signs
    prog.push_back(enc_i('h13, 0, 1, 0, 'h123));
    prog.push_back(enc_i('h13, 0, 2, 1, -5));
    prog.push_back(enc_r(0, 0, 3, 1, 2));
    prog.push_back(enc_r('h20, 0, 4, 3, 1));
    prog.push_back(enc_i('h13, 4, 5, 4, 'h7ff));
    prog.push_back(enc_i('h13, 6, 6, 5, -2048));
    prog.push_back(enc_i('h13, 7, 7, 6, 'h0f0));
    prog.push_back(enc_r(0, 7, 8, 6, 5));
    prog.push_back(enc_r(0, 6, 9, 8, 2));
    prog.push_back(enc_r(0, 4, 10, 9, 3));
    // store then load back, load followed by its use
    prog.push_back(enc_s(10, 0, 'h100));
    prog.push_back(enc_i('h03, 3, 11, 0, 'h100));
    prog.push_back(enc_r(0, 0, 12, 11, 1));
    prog.push_back(enc_i('h03, 3, 13, 0, 'h48));
    prog.push_back(enc_r('h20, 0, 14, 13, 12));
    // writes to x0, then x0 as a source
    prog.push_back(enc_i('h13, 0, 0, 1, 77));
    prog.push_back(enc_r(0, 0, 15, 0, 2));
    prog.push_back(enc_r(0, 0, 0, 1, 2));
    prog.push_back(enc_i('h13, 0, 16, 0, 'h80));
    prog.push_back(enc_s(14, 16, 'h18));
    prog.push_back(enc_i('h03, 3, 17, 16, 'h18));
    // encodings outside the kept set: lui shape, lw, sll, mul
    prog.push_back(enc_i('h37, 2, 18, 9, 'h123));
    prog.push_back(enc_i('h03, 2, 19, 0, 'h48));
    prog.push_back(enc_r(0, 1, 20, 1, 2));
    prog.push_back(enc_r(1, 0, 21, 1, 2));
    prog.push_back(enc_r(0, 0, 22, 18, 19));
    prog.push_back(enc_s(3, 0, 'h1f8));
    prog.push_back(enc_s(4, 0, 'h1f0));
    prog.push_back(enc_i('h03, 3, 23, 0, 'h1f8));
    prog.push_back(enc_r(0, 4, 24, 23, 4));
    prog.push_back(enc_i('h03, 3, 25, 0, 'h1f0));
    prog.push_back(enc_i('h13, 0, 26, 25, 1));
    prog.push_back(enc_s(26, 0, 0));
    prog.push_back(enc_i('h03, 3, 27, 0, 0));
    prog.push_back(enc_r(0, 6, 28, 27, 24));
    prog.push_back(enc_i('h13, 0, 29, 28, -1));
  endtask

  initial begin
    void'($urandom(32'hba0a3837));
    clock = 1'b0;
    reset = 1'b1;
    build_program();
    cycle_limit = 200 + 30 * prog.size();
    // words past the program hold addi x0, x0, 0
    for (int i = 0; i < 256; i++) begin
      u_tb_memory.imem[i] = (i < prog.size()) ? prog[i] : 32'h0000_0013;
    end
    repeat (10) begin
      @(negedge clock);
      compare_value("retire_valid", 64'(retire_valid), 64'h0);
      compare_value("if_rw_valid", 64'(if_rw_valid), 64'h0);
      compare_value("mem_rw_valid", 64'(mem_rw_valid), 64'h0);
    end
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = '0;
    end
    for (int i = 0; i < 64; i++) begin
      model_mem[i] = u_tb_memory.dmem[i];
    end
    for (int i = 0; i < prog.size(); i++) begin
      step_model(prog[i], 64'(i) * 64'd4);
    end
    reset = 1'b0;
    while (!if_rw_valid) begin
      @(negedge clock);
    end
    compare_value("if_rw_addr", if_rw_addr, 64'h0);
  end

  // retire pulses and write transfers against the model, in order
  always @(negedge clock) begin
    if (!reset) begin
      if (retire_valid) begin
        if (exp_pc.size() == 0) begin
          stop_run("retire pulse seen after every instruction had retired");
        end
        compare_value("retire_pc", retire_pc, exp_pc.pop_front());
        compare_value("retire_inst", 64'(retire_inst), 64'(exp_inst.pop_front()));
        compare_value("retire_wen", 64'(retire_wen), 64'(exp_wen[0]));
        if (exp_wen[0]) begin
          compare_value("retire_rd", 64'(retire_rd), 64'(exp_rd[0]));
          compare_value("retire_data", retire_data, exp_data[0]);
        end
        void'(exp_wen.pop_front());
        void'(exp_rd.pop_front());
        void'(exp_data.pop_front());
      end
      if (store_seen) begin
        if (exp_store_addr.size() == 0) begin
          stop_run("write transfer seen with no store left to match");
        end
        compare_value("mem_rw_addr", store_addr, exp_store_addr.pop_front());
        compare_value("mem_w_data", store_data, exp_store_data.pop_front());
      end
      if (exp_pc.size() == 0 && exp_store_addr.size() == 0) begin
        $display("** PASS **");
        $finish;
      end
    end
  end

  always @(posedge clock) begin
    cycle_count = cycle_count + 1;
    if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
      stop_run($sformatf("timeout: program did not retire within %0d cycles", cycle_limit));
    end
  end

endmodule

/* compile.f */
verilog/rv_pkg.sv
verilog/fetch_stage.sv
verilog/register_file.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/memory_stage.sv
verilog/writeback_stage.sv
verilog/cpu_core.sv
bench/tb_memory.sv
bench/cpu_core_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the core and its testbench with Verilator, run it, and look for the pass line.
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert --top-module cpu_core_tb -Mdir obj_dir -f compile.f; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/Vcpu_core_tb 2>&1)
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qxF '** PASS **'; then
  exit 0
else
  echo "pass line not found in simulation output"
  exit 1
fi
